// File: Bender.yml
package:
  name: video_upscan

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/upscan_pkg.sv
      - source/scan_ctrl.sv
      - stretch/line_store.sv
      - stretch/stretch_sequencer.sv
      - stretch/pixel_blend.sv
      - source/video_upscan.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_video_upscan.sv

// File: common/upscan_params.svh
/*
 * Timing constants for the 15 kHz to 31 kHz upscan
 *   Output horizontal and vertical timing
 *   Line store bank depth
 *   Input capture windows for the 720, 640 and 576 pixel modes
 */

`ifndef UPSCAN_PARAMS_SVH
`define UPSCAN_PARAMS_SVH

// Output line, in DCLK cycles
`define H_TOTAL       10'd855
`define H_SYNC        10'd62
`define H_ERASE       10'd69
`define H_DISP        10'd720

// Output frame, in lines
`define V_TOTAL       10'd525
`define V_SYNC        10'd2

// Words in one bank of the line store
`define LINE_WORDS    11'd768

// Input windows, in pixels after the hsync falling edge
`define WIN_START_720 10'd69
`define WIN_WIDTH_720 10'd720
`define WIN_START_640 10'd128
`define WIN_WIDTH_640 10'd640
`define WIN_START_576 10'd96
`define WIN_WIDTH_576 10'd576

`endif

// File: common/upscan_pkg.sv
/*
 * Shared types for the upscan datapath
 *   pixel_t        RGB pixel, 8 bits per channel
 *   upscan_mode_t  input width selection
 *   blend_weight_t previous sample weight in eighths
 *   line_addr_t    word address across both line store banks
 */

package upscan_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef enum logic [1:0] {
        MODE_720 = 2'd0,  // Native width
        MODE_640 = 2'd1,  // Stretched by 9/8
        MODE_576 = 2'd2   // Stretched by 5/4
    } upscan_mode_t;

    // 0 takes the current sample only, 8 the previous sample only
    typedef logic [3:0] blend_weight_t;

    typedef logic [10:0] line_addr_t;

endpackage

// File: list.f
+incdir+common
common/upscan_pkg.sv
source/scan_ctrl.sv
stretch/line_store.sv
stretch/stretch_sequencer.sv
stretch/pixel_blend.sv
source/video_upscan.sv
tests/tb_video_upscan.sv

// File: source/scan_ctrl.sv
/*
 * Scan control
 *   Input sync edge detection and capture window per mode
 *   Write bank selection
 *   Output H/V counters realigned on input vsync
 *   Output syncs, read line start, read bank and read window
 */

`timescale 1ns/1ps
`include "upscan_params.svh"

module scan_ctrl
    import upscan_pkg::*;
(
    input  logic         DCLK,
    input  logic         RESET_n,
    input  upscan_mode_t mode,
    input  logic         in_pix_en,
    input  logic         in_hs_n,
    input  logic         in_vs_n,
    output logic         wr_line_start,
    output logic         wr_bank,
    output logic         wr_active,
    output logic         rd_line_start,
    output logic         rd_bank,
    output logic         rd_active,
    output logic         out_hs_n,
    output logic         out_vs_n
);

    // Sequencer, RAM and blend stages between rd_active and out_de
    localparam logic [9:0] RD_LEAD = 10'd3;

    logic       hs_prev;
    logic       vs_prev;
    logic       hs_fall;
    logic       vs_fall;
    logic [9:0] in_h_cnt;
    logic [9:0] pix_idx;
    logic [9:0] win_start;
    logic [9:0] win_width;
    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic [1:0] line_cnt;
    logic       h_wrap;
    logic       v_wrap;

    // Syncs only mean something on a pixel strobe
    assign hs_fall = in_pix_en && hs_prev && !in_hs_n;
    assign vs_fall = in_pix_en && vs_prev && !in_vs_n;
    assign pix_idx = hs_fall ? 10'd0 : in_h_cnt;  // Edge pixel is index 0

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            hs_prev <= 1'b1;
            vs_prev <= 1'b1;
        end else if (in_pix_en) begin
            hs_prev <= in_hs_n;
            vs_prev <= in_vs_n;
        end
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            in_h_cnt <= '0;
        end else if (hs_fall) begin
            in_h_cnt <= 10'd1;
        end else if (in_pix_en && in_h_cnt != 10'h3ff) begin
            in_h_cnt <= in_h_cnt + 10'd1;  // Saturates without syncs
        end
    end

    always_comb begin
        case (mode)
            MODE_640: begin
                win_start = `WIN_START_640;
                win_width = `WIN_WIDTH_640;
            end
            MODE_576: begin
                win_start = `WIN_START_576;
                win_width = `WIN_WIDTH_576;
            end
            default: begin
                win_start = `WIN_START_720;
                win_width = `WIN_WIDTH_720;
            end
        endcase
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_line_start <= 1'b0;
            wr_active     <= 1'b0;
            wr_bank       <= 1'b1;
        end else begin
            wr_line_start <= hs_fall;
            wr_active     <= in_pix_en && (pix_idx >= win_start)
                             && (pix_idx < win_start + win_width);
            if (vs_fall)
                wr_bank <= 1'b1;      // Frame starts in bank 1
            else if (hs_fall)
                wr_bank <= !wr_bank;  // Ping-pong per input line
        end
    end

    // Output timing
    assign h_wrap = (h_cnt == `H_TOTAL - 10'd1);
    assign v_wrap = (v_cnt == `V_TOTAL - 10'd1);

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            line_cnt <= '0;
        end else if (vs_fall) begin
            h_cnt    <= '0;  // Lock output frame to input vsync
            v_cnt    <= '0;
            line_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt    <= '0;
            v_cnt    <= v_wrap ? 10'd0 : v_cnt + 10'd1;
            line_cnt <= line_cnt + 2'd1;
        end else begin
            h_cnt    <= h_cnt + 10'd1;
        end
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            out_hs_n      <= 1'b1;
            out_vs_n      <= 1'b1;
            rd_line_start <= 1'b0;
            rd_bank       <= 1'b0;
            rd_active     <= 1'b0;
        end else begin
            out_hs_n      <= (h_cnt >= `H_SYNC);
            out_vs_n      <= (v_cnt >= `V_SYNC);
            rd_line_start <= (h_cnt == 10'd1);
            if (h_cnt == 10'd1)
                rd_bank <= line_cnt[1];  // Each input line read twice
            rd_active     <= (h_cnt >= `H_ERASE - RD_LEAD)
                             && (h_cnt < `H_ERASE - RD_LEAD + `H_DISP);
        end
    end

endmodule

// File: source/video_upscan.sv
/*
 * Upscan top level
 *   Converts 15 kHz input lines into 31 kHz output lines at 720 pixels.
 *   Wires scan control, line store, read sequencer and blend stage.
 */

`timescale 1ns/1ps

module video_upscan
    import upscan_pkg::*;
(
    input  logic         DCLK,
    input  logic         RESET_n,
    input  upscan_mode_t mode,
    input  logic         in_pix_en,
    input  pixel_t       in_pixel,
    input  logic         in_hs_n,
    input  logic         in_vs_n,
    output pixel_t       out_pixel,
    output logic         out_hs_n,
    output logic         out_vs_n,
    output logic         out_de
);

    logic          wr_line_start;
    logic          wr_bank;
    logic          wr_active;
    logic          rd_line_start;
    logic          rd_bank;
    logic          rd_active;
    line_addr_t    rd_addr;
    blend_weight_t weight;
    logic          blend_en;
    pixel_t        rd_pixel;

    scan_ctrl i_scan_ctrl (
        .DCLK          (DCLK),
        .RESET_n       (RESET_n),
        .mode          (mode),
        .in_pix_en     (in_pix_en),
        .in_hs_n       (in_hs_n),
        .in_vs_n       (in_vs_n),
        .wr_line_start (wr_line_start),
        .wr_bank       (wr_bank),
        .wr_active     (wr_active),
        .rd_line_start (rd_line_start),
        .rd_bank       (rd_bank),
        .rd_active     (rd_active),
        .out_hs_n      (out_hs_n),
        .out_vs_n      (out_vs_n)
    );

    line_store i_line_store (
        .DCLK          (DCLK),
        .RESET_n       (RESET_n),
        .wr_line_start (wr_line_start),
        .wr_bank       (wr_bank),
        .wr_active     (wr_active),
        .wr_pixel      (in_pixel),
        .rd_addr       (rd_addr),
        .rd_pixel      (rd_pixel)
    );

    stretch_sequencer i_stretch_sequencer (
        .DCLK          (DCLK),
        .RESET_n       (RESET_n),
        .mode          (mode),
        .rd_line_start (rd_line_start),
        .rd_bank       (rd_bank),
        .rd_active     (rd_active),
        .rd_addr       (rd_addr),
        .weight        (weight),
        .blend_en      (blend_en)
    );

    pixel_blend i_pixel_blend (
        .DCLK          (DCLK),
        .RESET_n       (RESET_n),
        .rd_line_start (rd_line_start),
        .blend_en      (blend_en),
        .weight        (weight),
        .rd_pixel      (rd_pixel),
        .out_pixel     (out_pixel),
        .out_de        (out_de)
    );

endmodule

// File: stretch/line_store.sv
/*
 * Two-bank line store
 *   Write address counter reloaded with the bank base per line
 *   Inferred RAM with registered read port
 */

`timescale 1ns/1ps
`include "upscan_params.svh"

module line_store
    import upscan_pkg::*;
(
    input  logic       DCLK,
    input  logic       RESET_n,
    input  logic       wr_line_start,
    input  logic       wr_bank,
    input  logic       wr_active,
    input  pixel_t     wr_pixel,
    input  line_addr_t rd_addr,
    output pixel_t     rd_pixel
);

    pixel_t     mem [0:2*`LINE_WORDS-1];
    pixel_t     wr_data;
    line_addr_t wr_addr;

    // Pixel arrives with the strobe, wr_active one cycle later
    always_ff @(posedge DCLK) begin
        wr_data <= wr_pixel;
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wr_addr <= '0;
        end else if (wr_line_start) begin
            wr_addr <= wr_bank ? `LINE_WORDS : 11'd0;  // Bank base
        end else if (wr_active) begin
            wr_addr <= wr_addr + 11'd1;
        end
    end

    always_ff @(posedge DCLK) begin
        if (wr_active)
            mem[wr_addr] <= wr_data;
    end

    // One cycle read latency
    always_ff @(posedge DCLK) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

// File: stretch/pixel_blend.sv
/*
 * Two-tap horizontal blend
 *   Previous sample register
 *   Per channel weighted sum in eighths, truncated
 */

`timescale 1ns/1ps

module pixel_blend
    import upscan_pkg::*;
(
    input  logic          DCLK,
    input  logic          RESET_n,
    input  logic          rd_line_start,
    input  logic          blend_en,
    input  blend_weight_t weight,
    input  pixel_t        rd_pixel,
    output pixel_t        out_pixel,
    output logic          out_de
);

    pixel_t prev_pixel;
    pixel_t mix;

    // w eighths of the previous sample, the rest from the current one
    function automatic logic [7:0] blend_ch(input logic [7:0] p, input logic [7:0] c,
                                            input blend_weight_t w);
        logic [11:0] sum;
        sum = {4'd0, p} * {8'd0, w} + {4'd0, c} * {8'd0, 4'd8 - w};
        return sum[10:3];
    endfunction

    assign mix.r = blend_ch(prev_pixel.r, rd_pixel.r, weight);
    assign mix.g = blend_ch(prev_pixel.g, rd_pixel.g, weight);
    assign mix.b = blend_ch(prev_pixel.b, rd_pixel.b, weight);

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            prev_pixel <= '0;
            out_pixel  <= '0;
            out_de     <= 1'b0;
        end else begin
            out_de <= blend_en;
            if (rd_line_start) begin
                prev_pixel <= '0;  // Left edge blends against black
                out_pixel  <= '0;
            end else if (blend_en) begin
                prev_pixel <= rd_pixel;
                out_pixel  <= mix;
            end
        end
    end

endmodule

// File: stretch/stretch_sequencer.sv
/*
 * Read sequencer for horizontal stretch
 *   Phase counter per mode: 9 phases at 640, 5 at 576, 1 at 720
 *   Read address stepping and blend weight per phase
 *   Weight and enable delayed to line up with RAM data
 */

`timescale 1ns/1ps
`include "upscan_params.svh"

module stretch_sequencer
    import upscan_pkg::*;
(
    input  logic          DCLK,
    input  logic          RESET_n,
    input  upscan_mode_t  mode,
    input  logic          rd_line_start,
    input  logic          rd_bank,
    input  logic          rd_active,
    output line_addr_t    rd_addr,
    output blend_weight_t weight,
    output logic          blend_en
);

    logic [3:0]    phase;
    logic [3:0]    last_phase;
    logic          addr_step;
    line_addr_t    addr_cnt;
    blend_weight_t phase_weight;
    blend_weight_t weight_q;
    logic          issue_q;

    always_comb begin
        case (mode)
            MODE_640: begin
                last_phase   = 4'd8;
                addr_step    = (phase != 4'd7);  // Sample 7 feeds two outputs
                phase_weight = phase;
            end
            MODE_576: begin
                last_phase   = 4'd4;
                addr_step    = (phase != 4'd3);
                phase_weight = {phase[2:0], 1'b0};  // Quarters as eighths
            end
            default: begin
                last_phase   = 4'd0;
                addr_step    = 1'b1;
                phase_weight = 4'd0;  // Straight copy
            end
        endcase
    end

    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            phase    <= '0;
            addr_cnt <= '0;
        end else if (rd_line_start) begin
            phase    <= '0;
            addr_cnt <= rd_bank ? `LINE_WORDS : 11'd0;
        end else if (rd_active) begin
            phase    <= (phase >= last_phase) ? 4'd0 : phase + 4'd1;
            addr_cnt <= addr_cnt + {10'd0, addr_step};
        end
    end

    // Address stage
    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            rd_addr  <= '0;
            weight_q <= '0;
            issue_q  <= 1'b0;
        end else begin
            issue_q <= rd_active;
            if (rd_active) begin
                rd_addr  <= addr_cnt;
                weight_q <= phase_weight;
            end
        end
    end

    // Matches the RAM read latency
    always_ff @(posedge DCLK or negedge RESET_n) begin
        if (!RESET_n) begin
            weight   <= '0;
            blend_en <= 1'b0;
        end else begin
            weight   <= weight_q;
            blend_en <= issue_q;
        end
    end

endmodule

// File: tests/tb_video_upscan.sv
/*
 * Testbench for the upscan top level
 *   Clock, reset and input line stimulus per mode
 *   Reference stretch function for the expected output pixels
 *   Output timing monitor and per-run pixel compare
 */

`timescale 1ns/1ps
`include "upscan_params.svh"

module tb_video_upscan
    import upscan_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int LINE_LEN       = 855;  // Input pixel strobes per line
    localparam int HS_LEN         = 64;
    localparam int VS_LINES       = 3;
    localparam int FRAME_LINES    = 6;
    localparam int FRAMES         = 2;
    localparam int H_TOTAL_C      = `H_TOTAL;
    localparam int H_SYNC_C       = `H_SYNC;
    localparam int H_ERASE_C      = `H_ERASE;
    localparam int H_DISP_C       = `H_DISP;
    localparam int V_SYNC_C       = `V_SYNC;
    localparam int SKIP_CYCLES    = 4 * H_TOTAL_C;
    localparam int RUNS_PER_PHASE = FRAMES * FRAME_LINES * 2 - 4;

    logic         DCLK;
    logic         RESET_n;
    upscan_mode_t mode;
    logic         in_pix_en;
    pixel_t       in_pixel;
    logic         in_hs_n;
    logic         in_vs_n;
    pixel_t       out_pixel;
    logic         out_hs_n;
    logic         out_vs_n;
    logic         out_de;

    pixel_t       line_buf [0:LINE_LEN-1];  // Content repeated on every line of a phase
    pixel_t       run_buf [0:1023];
    upscan_mode_t phase_mode;
    time          mode_change_t;
    time          check_from = '1;
    time          vs_drive_t;
    time          hs_fall_t;
    time          de_rise_t;
    time          vs_fall_t;
    time          run_start_t;
    bit           vs_driven;
    bit           stim_on;
    bit           in_run;
    int           run_len;
    int           vs_realigns;
    int           checked_runs [0:2];
    logic         hs_q = 1'b1;
    logic         de_q = 1'b0;
    logic         vs_q = 1'b1;
    logic [31:0]  rnd;

    video_upscan i_video_upscan (
        .DCLK      (DCLK),
        .RESET_n   (RESET_n),
        .mode      (mode),
        .in_pix_en (in_pix_en),
        .in_pixel  (in_pixel),
        .in_hs_n   (in_hs_n),
        .in_vs_n   (in_vs_n),
        .out_pixel (out_pixel),
        .out_hs_n  (out_hs_n),
        .out_vs_n  (out_vs_n),
        .out_de    (out_de)
    );

    initial begin
        DCLK = 1'b0;
        forever #(CLK_PERIOD / 2) DCLK = ~DCLK;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    function automatic int cycles_since(input time t);
        return int'(($time - t) / CLK_PERIOD);
    endfunction

    function automatic int window_start(input upscan_mode_t m);
        case (m)
            MODE_640: return `WIN_START_640;
            MODE_576: return `WIN_START_576;
            default:  return `WIN_START_720;
        endcase
    endfunction

    // k parts of the left sample and s-k parts of the right one in units of 1/s
    function automatic logic [7:0] mix_chan(input logic [7:0] p, input logic [7:0] c,
                                            input int k, input int s);
        int v;
        v = (k * p + (s - k) * c) / s;
        return v[7:0];
    endfunction

    function automatic pixel_t stretch_ref(input upscan_mode_t m,
                                           input pixel_t line [0:LINE_LEN-1], input int j);
        int     base;
        int     s;
        int     g;
        int     k;
        pixel_t prev;
        pixel_t cur;
        pixel_t res;
        base = window_start(m);  // x[0] is the first pixel inside the window
        if (m == MODE_720)
            return line[base + j];
        s = (m == MODE_640) ? 8 : 4;
        g = j / (s + 1);
        k = j % (s + 1);
        if (k == s)
            return line[base + s * g + s - 1];  // Last sample of the group repeated
        cur  = line[base + s * g + k];
        prev = (s * g + k == 0) ? '0 : line[base + s * g + k - 1];
        res.r = mix_chan(prev.r, cur.r, k, s);
        res.g = mix_chan(prev.g, cur.g, k, s);
        res.b = mix_chan(prev.b, cur.b, k, s);
        return res;
    endfunction

    task automatic wait_vs_level(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (out_vs_n !== level) begin
            @(posedge DCLK);
            n++;
            if (n > max_cycles) begin
                $display("Timeout: out_vs_n did not reach %0b in %0d cycles", level, max_cycles);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
    endtask

    task automatic wait_de_low(input int max_cycles);
        int n;
        n = 0;
        while (out_de !== 1'b0) begin
            @(posedge DCLK);
            n++;
            if (n > max_cycles) begin
                $display("Timeout: out_de stayed high for %0d cycles", max_cycles);
                $display("Simulation FAILED");
                $fatal(1);
            end
        end
    endtask

    // One input line with a pixel strobe on every other cycle
    task automatic drive_line(input int line_no);
        int i;
        for (i = 0; i < LINE_LEN; i++) begin
            @(posedge DCLK);
            in_pix_en <= 1'b1;
            in_pixel  <= line_buf[i];
            in_hs_n   <= (i >= HS_LEN);
            in_vs_n   <= (line_no >= VS_LINES);
            if (i == 0 && line_no == 0) begin
                if (!vs_driven)
                    check_from = $time + 3 * H_TOTAL_C * CLK_PERIOD;  // After realignment
                vs_driven  = 1'b1;
                vs_drive_t = $time;
            end
            @(posedge DCLK);
            in_pix_en <= 1'b0;
        end
    endtask

    task automatic run_phase(input upscan_mode_t m);
        int i;
        int f;
        mode          <= m;
        phase_mode    = m;
        mode_change_t = $time;
        stim_on       = 1'b1;
        for (i = 0; i < LINE_LEN; i++) begin
            rnd = $urandom;
            line_buf[i] = rnd[23:0];
        end
        for (f = 0; f < FRAMES * FRAME_LINES; f++)
            drive_line(f % FRAME_LINES);
    endtask

    task automatic compare_run();
        int j;
        check_value("out_de run length", run_len, H_DISP_C);
        for (j = 0; j < H_DISP_C; j++)
            check_value("out_pixel", {8'd0, run_buf[j]},
                        {8'd0, stretch_ref(phase_mode, line_buf, j)});
        checked_runs[int'(phase_mode)]++;
    endtask

    // Output timing monitor
    always @(posedge DCLK) begin
        if (RESET_n) begin
            if (hs_q && !out_hs_n) begin
                if (hs_fall_t >= check_from)
                    check_value("out_hs_n period", cycles_since(hs_fall_t), H_TOTAL_C);
                hs_fall_t = $time;
            end
            if (!hs_q && out_hs_n && hs_fall_t >= check_from)
                check_value("out_hs_n low width", cycles_since(hs_fall_t), H_SYNC_C);
            if (!de_q && out_de) begin
                if (hs_fall_t >= check_from)
                    check_value("out_de delay", cycles_since(hs_fall_t), H_ERASE_C);
                de_rise_t = $time;
            end
            if (de_q && !out_de && de_rise_t >= check_from)
                check_value("out_de width", cycles_since(de_rise_t), H_DISP_C);
            if (vs_q && !out_vs_n) begin
                if (vs_driven) begin  // Drive edge plus one cycle until the DUT samples it
                    check_value("out_vs_n realign delay ok",
                                {31'd0, cycles_since(vs_drive_t) - 1 <= 3}, 32'd1);
                    vs_realigns++;
                end
                vs_fall_t = $time;
            end
            if (!vs_q && out_vs_n && vs_fall_t >= check_from)
                check_value("out_vs_n low width", cycles_since(vs_fall_t),
                            V_SYNC_C * H_TOTAL_C);
        end
        hs_q = out_hs_n;
        de_q = out_de;
        vs_q = out_vs_n;
    end

    // Collects each out_de run and compares it once complete
    always @(posedge DCLK) begin
        if (out_de) begin
            if (!in_run) begin
                in_run      = 1'b1;
                run_start_t = $time;
                run_len     = 0;
            end
            if (run_len < 1024)
                run_buf[run_len] = out_pixel;
            run_len++;
        end else if (in_run) begin
            in_run = 1'b0;
            if (stim_on && run_start_t >= mode_change_t + SKIP_CYCLES * CLK_PERIOD)
                compare_run();
        end
    end

    initial begin
        rnd       = $urandom(32'h6d34);
        RESET_n   = 1'b0;
        mode      = MODE_720;
        in_pix_en = 1'b0;
        in_pixel  = '0;
        in_hs_n   = 1'b1;
        in_vs_n   = 1'b1;

        repeat (4) @(posedge DCLK);
        check_value("out_hs_n", {31'd0, out_hs_n}, 32'd1);
        check_value("out_vs_n", {31'd0, out_vs_n}, 32'd1);
        check_value("out_de", {31'd0, out_de}, 32'd0);
        check_value("out_pixel", {8'd0, out_pixel}, 32'd0);
        RESET_n <= 1'b1;

        wait_vs_level(1'b0, 4 * H_TOTAL_C);
        wait_vs_level(1'b1, 4 * H_TOTAL_C);
        repeat (300) @(posedge DCLK);  // Output free runs at some phase before the first vsync

        run_phase(MODE_720);
        run_phase(MODE_640);
        run_phase(MODE_576);
        wait_de_low(2 * H_TOTAL_C);

        check_value("out_vs_n realign count", vs_realigns, 3 * FRAMES);
        check_value("checked runs 720", checked_runs[0], RUNS_PER_PHASE);
        check_value("checked runs 640", checked_runs[1], RUNS_PER_PHASE);
        check_value("checked runs 576", checked_runs[2], RUNS_PER_PHASE);
        $display("Simulation PASSED");
        $finish;
    end

endmodule
